// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_camera_scan_out
FILELIST   := list.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
PASS_TEXT  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/scan_out_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_out_assertions (
    input logic                            pix_clk,
    input logic                            resetn,
    input logic [scan_pkg::count_bits-1:0] count_q,
    input logic                            rel_valid,
    input logic [scan_pkg::num_bufs-1:0]   rel_mask,
    input logic [scan_pkg::num_bufs-1:0]   rel_n,
    input logic [scan_pkg::buf_bits-1:0]   cur_idx,
    input logic                            cur_valid
);

    fill_in_range: assert property (@(posedge pix_clk) disable iff (!resetn)
        count_q <= scan_pkg::count_bits'(scan_pkg::desc_depth))
        else $error("descriptor fill count above FIFO depth");

    release_not_empty: assert property (@(posedge pix_clk) disable iff (!resetn)
        rel_valid |-> (rel_mask != '0))
        else $error("release pulse with an empty mask");

    // the buffer on screen after this cycle must not go back to the free map
    current_kept: assert property (@(posedge pix_clk) disable iff (!resetn)
        cur_valid |-> !rel_n[cur_idx])
        else $error("current display buffer released");

endmodule

bind line_scheduler scan_out_assertions i_sched_checks (
    .pix_clk(pix_clk), .resetn(resetn), .count_q(count_q),
    .rel_valid(handoff.rel_valid), .rel_mask(handoff.rel_mask),
    .rel_n(rel_n), .cur_idx(cur_idx), .cur_valid(cur_valid)
);

`default_nettype wire

// ==== bench/tb_camera_scan_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_camera_scan_out;

    localparam int frame_cycles = 24 * 17;

    logic        pix_clk;
    logic        resetn;
    logic        cam_line_valid;
    logic        cam_y_valid;
    logic [7:0]  cam_y;
    logic        de;
    logic        hsync;
    logic        vsync;
    logic [7:0]  pixel;

    logic [31:0] lfsr;
    logic [7:0]  row [16];
    logic        prev_de = 1'b0;
    logic        prev_hs = 1'b1;
    logic        prev_vs = 1'b1;
    logic        shown = 1'b0;
    int          x = 0;
    int          hs_run = 0;
    int          vs_run = 0;
    int          row_idx = 0;
    int          frames = 0;
    int          seq = 0;
    int          lines_done = 0;
    int          last_full = 0;
    int          changes = 0;
    int          skips = 0;
    int          rows_checked = 0;
    int          errors = 0;
    int          test_start_errors = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          snap;

    tb_clock #(.half_period(20), .reset_cycles(8)) i_clock (
        .pix_clk(pix_clk), .resetn(resetn)
    );

    camera_scan_out #(
        .h_active(16), .h_fp(2), .h_sync(4), .h_bp(2),
        .v_active(12), .v_fp(1), .v_sync(2), .v_bp(2)
    ) i_dut (
        .pix_clk(pix_clk), .resetn(resetn),
        .cam_line_valid(cam_line_valid), .cam_y_valid(cam_y_valid), .cam_y(cam_y),
        .de(de), .hsync(hsync), .vsync(vsync), .pixel(pixel)
    );

    // --------------------
    // random source
    // --------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
    endtask

    task automatic wait_reset();
        int t;
        t = 0;
        while (!resetn && t < 100) begin
            @(negedge pix_clk);
            t++;
        end
        assert (resetn) else report_timeout("reset release");
    endtask

    task automatic wait_frames(input int n);
        int target;
        int t;
        target = frames + n;
        t = 0;
        while (frames < target && t < n * frame_cycles + 100) begin
            @(negedge pix_clk);
            t++;
        end
        assert (frames >= target) else report_timeout("vsync");
    endtask

    // sample = {sequence tag, sample index}
    task automatic send_line(input int idle_min, input int idle_bits);
        logic [7:0] r;
        int         len;
        int         n;
        take_bits(3, r);
        len = 16 + int'(r) % 5;
        n = 0;
        cam_line_valid = 1'b1;
        while (n < len) begin
            take_bits(2, r);
            cam_y_valid = (r != 8'd0);
            cam_y = {4'(seq), 4'(n)};
            if (r != 8'd0) begin
                n++;
            end
            @(negedge pix_clk);
        end
        cam_line_valid = 1'b0;
        cam_y_valid = 1'b0;
        seq++;
        lines_done = seq;
        take_bits(idle_bits, r);
        repeat (idle_min + int'(r)) @(negedge pix_clk);
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("%-14s ok", name);
        end else begin
            tests_bad++;
            $display("%-14s %0d errors", name, errors - test_start_errors);
        end
    endtask

    // --------------------
    // row model
    // --------------------
    task automatic check_row();
        logic       blank;
        logic       ok;
        logic [3:0] tag;
        logic [3:0] delta;
        int         full;
        int         bad_x;
        blank = 1'b1;
        ok = 1'b1;
        bad_x = 0;
        tag = row[0][7:4];
        for (int k = 15; k >= 0; k--) begin
            if (row[k] != 8'h00) begin
                blank = 1'b0;
            end
            if (row[k] != {tag, 4'(k)}) begin
                ok = 1'b0;
                bad_x = k;
            end
        end
        if (blank) begin
            assert (!shown) else begin
                $display("black row %0d after a line was on screen", row_idx);
                errors++;
            end
        end else begin
            assert (ok) else begin
                $display("Fail pixel: row %0d x %0d is %h, expected %h",
                         row_idx, bad_x, row[bad_x], {tag, 4'(bad_x)});
                errors++;
            end
            // first line: newest finished line with this tag
            if (!shown) begin
                full = lines_done - 1 - ((lines_done - 1 - int'(tag)) & 15);
            end else begin
                delta = tag - 4'(last_full);
                full = last_full + int'(delta);
            end
            assert (full >= 0 && full < lines_done) else begin
                $display("row %0d shows a line the camera has not finished", row_idx);
                errors++;
            end
            if (!shown || full != last_full) begin
                changes++;
                if (shown && full > last_full + 1) begin
                    skips++;
                end
                assert (row_idx % 2 == 0) else begin
                    $display("new line %0d started on odd row %0d", full, row_idx);
                    errors++;
                end
            end
            shown = 1'b1;
            last_full = full;
        end
        rows_checked++;
        row_idx++;
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge pix_clk) begin
        if (resetn) begin
            assert (de || pixel == 8'h00) else begin
                $display("Fail pixel: %h outside de, expected 00", pixel);
                errors++;
            end
            if (de) begin
                if (x < 16) begin
                    row[x] = pixel;
                end
                x++;
            end
            if (prev_de && !de) begin
                assert (x == 16) else begin
                    $display("Fail de: high for %0h cycles, expected 10", x);
                    errors++;
                end
                check_row();
                x = 0;
            end
            if (!hsync) begin
                hs_run++;
            end
            if (!prev_hs && hsync) begin
                assert (hs_run == 4) else begin
                    $display("Fail hsync: low for %0h cycles, expected 4", hs_run);
                    errors++;
                end
                hs_run = 0;
            end
            if (!vsync) begin
                vs_run++;
            end
            if (prev_vs && !vsync) begin
                assert (row_idx == 12) else begin
                    $display("Fail de: %0h active rows in frame, expected c", row_idx);
                    errors++;
                end
                frames++;
                row_idx = 0;
            end
            if (!prev_vs && vsync) begin
                assert (vs_run == 48) else begin
                    $display("Fail vsync: low for %0h cycles, expected 30", vs_run);
                    errors++;
                end
                vs_run = 0;
            end
            prev_de = de;
            prev_hs = hsync;
            prev_vs = vsync;
        end
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        cam_line_valid = 1'b0;
        cam_y_valid = 1'b0;
        cam_y = 8'h00;
        lfsr = 32'ha4b0_811f;
        wait_reset();

        begin_test();
        wait_frames(2);
        end_test("raster");

        begin_test();
        assert (!shown && rows_checked >= 24) else begin
            $display("picture shown before any camera line");
            errors++;
        end
        end_test("black start");

        // slower than the display drains
        begin_test();
        snap = changes;
        for (int i = 0; i < 40; i++) begin
            send_line(40, 5);
        end
        assert (changes - snap >= 36 && skips == 0) else begin
            $display("steady feed lost lines, %0d new lines shown", changes - snap);
            errors++;
        end
        end_test("steady feed");

        begin_test();
        snap = skips;
        for (int i = 0; i < 60; i++) begin
            send_line(1, 2);
        end
        assert (skips > snap) else begin
            $display("fast feed shown without any skipped line");
            errors++;
        end
        end_test("fast feed");

        begin_test();
        wait_frames(3);
        snap = changes;
        wait_frames(2);
        assert (shown && changes == snap) else begin
            $display("display changed line after the camera stopped");
            errors++;
        end
        end_test("drain repeat");

        $display("tests %0d, with errors %0d, rows %0d, check errors %0d",
                 tests_run, tests_bad, rows_checked, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int half_period  = 20,
    parameter int reset_cycles = 8
) (
    output logic pix_clk,
    output logic resetn
);

    initial begin
        pix_clk = 1'b0;
        forever #(half_period) pix_clk = ~pix_clk;
    end

    // release away from the sampling edge
    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge pix_clk);
        @(negedge pix_clk);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/scan_pkg.sv
rtl/line_handoff_if.sv
rtl/video_timing.sv
rtl/line_capture.sv
rtl/line_store.sv
rtl/line_scheduler.sv
rtl/camera_scan_out.sv
bench/tb_clock.sv
bench/scan_out_assertions.sv
bench/tb_camera_scan_out.sv

// ==== rtl/camera_scan_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module camera_scan_out #(
    parameter int h_active = scan_pkg::def_h_active,
    parameter int h_fp     = scan_pkg::def_h_fp,
    parameter int h_sync   = scan_pkg::def_h_sync,
    parameter int h_bp     = scan_pkg::def_h_bp,
    parameter int v_active = scan_pkg::def_v_active,
    parameter int v_fp     = scan_pkg::def_v_fp,
    parameter int v_sync   = scan_pkg::def_v_sync,
    parameter int v_bp     = scan_pkg::def_v_bp
) (
    input  logic                          pix_clk,
    input  logic                          resetn,
    input  logic                          cam_line_valid,
    input  logic                          cam_y_valid,
    input  logic [scan_pkg::pix_bits-1:0] cam_y,
    output logic                          de,
    output logic                          hsync,
    output logic                          vsync,
    output logic [scan_pkg::pix_bits-1:0] pixel
);

    logic                           raw_de;
    logic                           raw_hsync;
    logic                           raw_vsync;
    logic [scan_pkg::addr_bits-1:0] rd_addr;
    logic                           active_line_start;
    logic                           blank_line_start;
    logic                           frame_sync;
    logic                           wr_en;
    logic [scan_pkg::buf_bits-1:0]  wr_idx;
    logic [scan_pkg::addr_bits-1:0] wr_addr;
    logic [scan_pkg::pix_bits-1:0]  wr_data;
    logic [scan_pkg::pix_bits-1:0]  rd_data;
    logic [scan_pkg::buf_bits-1:0]  cur_idx;
    logic                           cur_valid;
    logic                           de_d1;
    logic                           hsync_d1;
    logic                           vsync_d1;
    logic                           valid_d1;

    line_handoff_if handoff ();

    video_timing #(
        .h_active(h_active), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
        .v_active(v_active), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp)
    ) i_timing (
        .pix_clk(pix_clk), .resetn(resetn),
        .de(raw_de), .hsync(raw_hsync), .vsync(raw_vsync), .rd_addr(rd_addr),
        .active_line_start(active_line_start), .blank_line_start(blank_line_start),
        .frame_sync(frame_sync)
    );

    line_capture #(.h_active(h_active)) i_capture (
        .pix_clk(pix_clk), .resetn(resetn),
        .cam_line_valid(cam_line_valid), .cam_y_valid(cam_y_valid), .cam_y(cam_y),
        .handoff(handoff),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    line_store #(.h_active(h_active)) i_store (
        .pix_clk(pix_clk),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_idx(cur_idx), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    line_scheduler i_sched (
        .pix_clk(pix_clk), .resetn(resetn), .handoff(handoff),
        .active_line_start(active_line_start), .blank_line_start(blank_line_start),
        .frame_sync(frame_sync), .cur_idx(cur_idx), .cur_valid(cur_valid)
    );

    // --------------------
    // output pipeline
    // --------------------
    // stage 1 runs alongside the memory read
    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            de_d1    <= 1'b0;
            hsync_d1 <= 1'b1;
            vsync_d1 <= 1'b1;
            valid_d1 <= 1'b0;
            de       <= 1'b0;
            hsync    <= 1'b1;
            vsync    <= 1'b1;
            pixel    <= '0;
        end else begin
            de_d1    <= raw_de;
            hsync_d1 <= raw_hsync;
            vsync_d1 <= raw_vsync;
            valid_d1 <= cur_valid;
            de       <= de_d1;
            hsync    <= hsync_d1;
            vsync    <= vsync_d1;
            // black until a line is on screen
            pixel    <= (de_d1 && valid_d1) ? rd_data : '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/line_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_capture #(
    parameter int h_active = scan_pkg::def_h_active
) (
    input  logic                           pix_clk,
    input  logic                           resetn,
    input  logic                           cam_line_valid,
    input  logic                           cam_y_valid,
    input  logic [scan_pkg::pix_bits-1:0]  cam_y,
    line_handoff_if.capture                handoff,
    output logic                           wr_en,
    output logic [scan_pkg::buf_bits-1:0]  wr_idx,
    output logic [scan_pkg::addr_bits-1:0] wr_addr,
    output logic [scan_pkg::pix_bits-1:0]  wr_data
);

    localparam int idx_w  = scan_pkg::buf_bits;
    localparam int addr_w = scan_pkg::addr_bits;

    logic [scan_pkg::num_bufs-1:0] free_map;
    logic [scan_pkg::num_bufs-1:0] free_next;
    logic [idx_w-1:0]              alloc_idx;
    logic                          alloc_ok;
    logic                          line_valid_d;
    logic                          line_rise;
    logic                          line_fall;
    logic [idx_w-1:0]              idx_q;
    logic [addr_w-1:0]             addr_q;
    logic                          drop_q;
    logic                          cur_drop;
    logic                          sample_ok;

    assign line_rise = cam_line_valid && !line_valid_d;
    assign line_fall = !cam_line_valid && line_valid_d;

    // lowest free buffer wins
    always_comb begin
        alloc_ok  = |free_map;
        alloc_idx = '0;
        for (int i = scan_pkg::num_bufs - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_idx = idx_w'(i);
            end
        end
    end

    always_comb begin
        free_next = free_map;
        if (handoff.rel_valid) begin
            free_next = free_next | handoff.rel_mask;
        end
        if (line_rise && alloc_ok) begin
            free_next[alloc_idx] = 1'b0;
        end
    end

    // --------------------
    // write side
    // --------------------
    // the first sample may arrive on the rising edge itself
    assign cur_drop  = line_rise ? !alloc_ok : drop_q;
    assign wr_idx    = line_rise ? alloc_idx : idx_q;
    assign wr_addr   = line_rise ? '0 : addr_q;
    assign sample_ok = cam_line_valid && cam_y_valid && !cur_drop;
    assign wr_en     = sample_ok && (wr_addr < addr_w'(h_active));
    assign wr_data   = cam_y;

    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            free_map           <= '1;
            line_valid_d       <= 1'b0;
            drop_q             <= 1'b0;
            addr_q             <= '0;
            handoff.desc_valid <= 1'b0;
        end else begin
            free_map     <= free_next;
            line_valid_d <= cam_line_valid;
            drop_q       <= cur_drop;
            // stop counting at the end of the visible line
            if (sample_ok && (wr_addr != addr_w'(h_active))) begin
                addr_q <= wr_addr + addr_w'(1);
            end else begin
                addr_q <= wr_addr;
            end
            handoff.desc_valid <= line_fall && !drop_q;
        end
    end

    always_ff @(posedge pix_clk) begin
        idx_q <= wr_idx;
        if (line_fall) begin
            handoff.desc_idx <= idx_q;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/line_handoff_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface line_handoff_if;

    // filled buffer, capture to display
    logic                          desc_valid;
    logic [scan_pkg::buf_bits-1:0] desc_idx;

    // buffers handed back, display to capture
    logic                          rel_valid;
    logic [scan_pkg::num_bufs-1:0] rel_mask;

    modport capture (output desc_valid, desc_idx, input rel_valid, rel_mask);
    modport sched (input desc_valid, desc_idx, output rel_valid, rel_mask);

endinterface

`default_nettype wire

// ==== rtl/line_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_scheduler (
    input  logic                          pix_clk,
    input  logic                          resetn,
    line_handoff_if.sched                 handoff,
    input  logic                          active_line_start,
    input  logic                          blank_line_start,
    input  logic                          frame_sync,
    output logic [scan_pkg::buf_bits-1:0] cur_idx,
    output logic                          cur_valid
);

    localparam int cnt_w = scan_pkg::count_bits;
    localparam int ptr_w = $clog2(scan_pkg::desc_depth);

    logic [scan_pkg::buf_bits-1:0] fifo_mem [scan_pkg::desc_depth];
    logic [ptr_w-1:0]              wr_ptr;
    logic [ptr_w-1:0]              rd_ptr;
    logic [cnt_w-1:0]              count_q;
    logic [cnt_w-1:0]              count_n;
    logic [scan_pkg::buf_bits-1:0] head;
    logic [scan_pkg::buf_bits-1:0] cur_idx_q;
    logic                          cur_valid_q;
    logic                          repeat_q;
    logic                          drop_req_q;
    logic                          push;
    logic                          fetch;
    logic                          drop;
    logic                          pop;
    logic                          over_wm;
    logic [scan_pkg::num_bufs-1:0] rel_n;

    function automatic logic [scan_pkg::num_bufs-1:0] buf_bit(
        input logic [scan_pkg::buf_bits-1:0] idx
    );
        logic [scan_pkg::num_bufs-1:0] v;
        v      = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    assign head    = fifo_mem[rd_ptr];
    assign over_wm = (count_q > cnt_w'(scan_pkg::high_wm));

    // --------------------
    // per-cycle decisions
    // --------------------
    always_comb begin
        push  = handoff.desc_valid && (count_q < cnt_w'(scan_pkg::desc_depth));
        // bob: new line only on every other active line
        fetch = active_line_start && !repeat_q && (count_q != '0);
        drop  = blank_line_start && (count_q != '0) && (drop_req_q || over_wm);
        pop   = fetch || drop;

        rel_n = '0;
        // full queue, hand the buffer straight back
        if (handoff.desc_valid && !push) begin
            rel_n = rel_n | buf_bit(handoff.desc_idx);
        end
        if (fetch && cur_valid_q) begin
            rel_n = rel_n | buf_bit(cur_idx_q);
        end
        if (drop) begin
            rel_n = rel_n | buf_bit(head);
        end

        case ({push, pop})
            2'b10:   count_n = count_q + cnt_w'(1);
            2'b01:   count_n = count_q - cnt_w'(1);
            default: count_n = count_q;
        endcase
    end

    // the new line is visible from its first read address
    assign cur_idx   = fetch ? head : cur_idx_q;
    assign cur_valid = cur_valid_q || fetch;

    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr           <= '0;
            rd_ptr           <= '0;
            count_q          <= '0;
            cur_idx_q        <= '0;
            cur_valid_q      <= 1'b0;
            repeat_q         <= 1'b0;
            drop_req_q       <= 1'b0;
            handoff.rel_valid <= 1'b0;
            handoff.rel_mask  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + ptr_w'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + ptr_w'(1);
            end
            count_q     <= count_n;
            cur_idx_q   <= cur_idx;
            cur_valid_q <= cur_valid;
            if (active_line_start) begin
                repeat_q <= !repeat_q;
            end
            // request from vsync is served on a later blank line
            if (frame_sync) begin
                drop_req_q <= over_wm;
            end else if (drop) begin
                drop_req_q <= 1'b0;
            end
            handoff.rel_valid <= |rel_n;
            handoff.rel_mask  <= rel_n;
        end
    end

    always_ff @(posedge pix_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= handoff.desc_idx;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_store #(
    parameter int h_active = scan_pkg::def_h_active
) (
    input  logic                           pix_clk,
    input  logic                           wr_en,
    input  logic [scan_pkg::buf_bits-1:0]  wr_idx,
    input  logic [scan_pkg::addr_bits-1:0] wr_addr,
    input  logic [scan_pkg::pix_bits-1:0]  wr_data,
    input  logic [scan_pkg::buf_bits-1:0]  rd_idx,
    input  logic [scan_pkg::addr_bits-1:0] rd_addr,
    output logic [scan_pkg::pix_bits-1:0]  rd_data
);

    localparam int mem_words = scan_pkg::num_bufs * h_active;
    localparam int mem_bits  = $clog2(mem_words);

    logic [scan_pkg::pix_bits-1:0] mem [mem_words];
    logic [mem_bits-1:0]           wr_loc;
    logic [mem_bits-1:0]           rd_loc;

    // buffer n occupies words n*h_active and up
    assign wr_loc = mem_bits'(wr_idx) * mem_bits'(h_active) + mem_bits'(wr_addr);
    assign rd_loc = mem_bits'(rd_idx) * mem_bits'(h_active) + mem_bits'(rd_addr);

    always_ff @(posedge pix_clk) begin
        if (wr_en) begin
            mem[wr_loc] <= wr_data;
        end
        // blanking addresses lie past the line
        rd_data <= (rd_addr < scan_pkg::addr_bits'(h_active)) ? mem[rd_loc] : '0;
    end

endmodule

`default_nettype wire

// ==== rtl/scan_pkg.sv ====
`default_nettype none

package scan_pkg;

    // --------------------
    // line buffers
    // --------------------
    localparam int num_bufs = 8;
    localparam int buf_bits = 3;

    // descriptor queue
    localparam int desc_depth = 16;
    localparam int count_bits = 5;
    localparam int high_wm    = 12;

    // pixel data and line addressing
    localparam int pix_bits  = 8;
    localparam int addr_bits = 10;

    // --------------------
    // default raster, 720x480
    // --------------------
    localparam int def_h_active = 720;
    localparam int def_h_fp     = 16;
    localparam int def_h_sync   = 62;
    localparam int def_h_bp     = 60;
    localparam int def_v_active = 480;
    localparam int def_v_fp     = 9;
    localparam int def_v_sync   = 6;
    localparam int def_v_bp     = 30;

endpackage

`default_nettype wire

// ==== rtl/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter int h_active = scan_pkg::def_h_active,
    parameter int h_fp     = scan_pkg::def_h_fp,
    parameter int h_sync   = scan_pkg::def_h_sync,
    parameter int h_bp     = scan_pkg::def_h_bp,
    parameter int v_active = scan_pkg::def_v_active,
    parameter int v_fp     = scan_pkg::def_v_fp,
    parameter int v_sync   = scan_pkg::def_v_sync,
    parameter int v_bp     = scan_pkg::def_v_bp
) (
    input  logic                           pix_clk,
    input  logic                           resetn,
    output logic                           de,
    output logic                           hsync,
    output logic                           vsync,
    output logic [scan_pkg::addr_bits-1:0] rd_addr,
    output logic                           active_line_start,
    output logic                           blank_line_start,
    output logic                           frame_sync
);

    localparam int h_total = h_active + h_fp + h_sync + h_bp;
    localparam int v_total = v_active + v_fp + v_sync + v_bp;
    localparam int h_bits  = $clog2(h_total);
    localparam int v_bits  = $clog2(v_total);
    localparam int addr_w  = scan_pkg::addr_bits;

    logic [h_bits-1:0] h_cnt;
    logic [v_bits-1:0] v_cnt;
    logic              line_begin;
    logic              v_visible;

    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == h_bits'(h_total - 1)) begin
            h_cnt <= '0;
            if (v_cnt == v_bits'(v_total - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + v_bits'(1);
            end
        end else begin
            h_cnt <= h_cnt + h_bits'(1);
        end
    end

    assign line_begin = (h_cnt == '0);
    assign v_visible  = (v_cnt < v_bits'(v_active));

    assign de    = (h_cnt < h_bits'(h_active)) && v_visible;
    // syncs are active low
    assign hsync = !((h_cnt >= h_bits'(h_active + h_fp)) &&
                     (h_cnt < h_bits'(h_active + h_fp + h_sync)));
    assign vsync = !((v_cnt >= v_bits'(v_active + v_fp)) &&
                     (v_cnt < v_bits'(v_active + v_fp + v_sync)));

    assign rd_addr = addr_w'(h_cnt);

    assign active_line_start = line_begin && v_visible;
    assign blank_line_start  = line_begin && !v_visible;
    // first cycle with vsync low
    assign frame_sync = line_begin && (v_cnt == v_bits'(v_active + v_fp));

endmodule

`default_nettype wire
